/* hw/ppu_pkg.sv */
`default_nettype none

package ppu_pkg;

    // vertical phase of the current row
    typedef enum logic [1:0] {
        VIS_SL    = 2'd0,
        POST_SL   = 2'd1,
        VBLANK_SL = 2'd2,
        PRE_SL    = 2'd3
    } vs_state_t;

    // horizontal phase of the current column
    typedef enum logic [1:0] {
        SL_PRE_CYC  = 2'd0,
        SL_SPR_CYC  = 2'd1,
        SL_IDLE_CYC = 2'd2
    } hs_state_t;

    typedef enum logic {
        HORZ_MIR = 1'b0,
        VERT_MIR = 1'b1
    } mirror_t;

    // background pattern table select
    typedef enum logic {
        LEFT_TBL  = 1'b0,
        RIGHT_TBL = 1'b1
    } pattern_tbl_t;

    // frame geometry
    localparam int SL_COLS = 341;
    localparam int SL_ROWS = 262;

    // column events
    localparam logic [8:0] LAST_COL     = 9'd340;
    localparam logic [8:0] SCROLL_V_COL = 9'd256;
    localparam logic [8:0] COPY_H_COL   = 9'd257;
    localparam logic [8:0] COPY_V_FIRST = 9'd280;
    localparam logic [8:0] COPY_V_LAST  = 9'd304;

    // nametable and attribute table bases
    localparam logic [15:0] NT_BASE = 16'h2000;
    localparam logic [15:0] AT_BASE = 16'h23C0;

endpackage

`default_nettype wire

/* hw/ppu_ifs.sv */
`default_nettype none

// row and column position with decoded phases
interface scan_if;
    import ppu_pkg::*;

    logic [8:0] sl_row;
    logic [8:0] sl_col;
    vs_state_t  vs_state;
    hs_state_t  hs_state;

    modport src (output sl_row, sl_col, vs_state, hs_state);
    modport snk (input sl_row, sl_col, vs_state, hs_state);
endinterface

// scroll address out, update requests back in
interface scroll_if;
    logic [15:0] vaddr;
    logic [2:0]  fine_x;
    logic        h_scroll;
    logic        v_scroll;
    logic        h_update;
    logic        v_update;

    modport regs (output vaddr, fine_x, input h_scroll, v_scroll, h_update, v_update);
    modport pix (input vaddr, fine_x, output h_scroll, v_scroll, h_update, v_update);
endinterface

`default_nettype wire

/* hw/vram_mirroring.sv */
`default_nettype none

module vram_mirroring (
    input  logic [15:0]       addr,
    input  ppu_pkg::mirror_t  mirroring,
    output logic [10:0]       vram_addr
);
    import ppu_pkg::*;

    logic page;

    // horizontal mirroring pairs tables 0/1 and 2/3
    always_comb begin
        if (mirroring == HORZ_MIR)
            page = addr[11];
        else
            page = addr[10];
    end

    assign vram_addr = {page, addr[9:0]};

endmodule

`default_nettype wire

/* hw/ppu_timing.sv */
`default_nettype none

module ppu_timing (
    input logic clk,
    input logic rst_n,
    input logic clk_en,
    scan_if.src scan
);
    import ppu_pkg::*;

    logic [8:0] col;
    logic [8:0] row;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col <= '0;
            row <= '0;
        end else if (clk_en) begin
            if (col == LAST_COL) begin
                col <= '0;
                // end of frame
                if (row == 9'(SL_ROWS - 1))
                    row <= '0;
                else
                    row <= row + 9'd1;
            end else begin
                col <= col + 9'd1;
            end
        end
    end

    // vertical phase from the row range
    always_comb begin
        if (row < 9'd240)
            scan.vs_state = VIS_SL;
        else if (row == 9'd240)
            scan.vs_state = POST_SL;
        else if (row < 9'(SL_ROWS - 1))
            scan.vs_state = VBLANK_SL;
        else
            scan.vs_state = PRE_SL;
    end

    // horizontal phase, prefetch window at 320..335
    always_comb begin
        if (col < SCROLL_V_COL)
            scan.hs_state = SL_PRE_CYC;
        else if (col < 9'd320)
            scan.hs_state = SL_SPR_CYC;
        else if (col < 9'd336)
            scan.hs_state = SL_PRE_CYC;
        else
            scan.hs_state = SL_IDLE_CYC;
    end

    assign scan.sl_row = row;
    assign scan.sl_col = col;

    a_col_range: assert property (@(posedge clk) disable iff (!rst_n) col < 9'(SL_COLS));

endmodule

`default_nettype wire

/* hw/scroll_regs.sv */
`default_nettype none

module scroll_regs (
    input logic        clk,
    input logic        rst_n,
    input logic        clk_en,
    input logic        scroll_wr,
    input logic [14:0] scroll_t,
    input logic [2:0]  fine_x_in,
    scroll_if.regs     scr
);
    // vaddr holds fine y in 14:12, nametable in 11:10, coarse y in 9:5 and coarse x in 4:0
    logic [14:0] v;
    logic [14:0] t;
    logic [2:0]  fx;
    logic [14:0] v_next;

    function automatic logic [14:0] inc_coarse_x(input logic [14:0] a);
        logic [14:0] r;
        r = a;
        if (a[4:0] == 5'd31) begin
            r[4:0] = 5'd0;
            r[10]  = ~a[10];
        end else begin
            r[4:0] = a[4:0] + 5'd1;
        end
        return r;
    endfunction

    function automatic logic [14:0] inc_fine_y(input logic [14:0] a);
        logic [14:0] r;
        r = a;
        if (a[14:12] != 3'd7) begin
            r[14:12] = a[14:12] + 3'd1;
        end else begin
            r[14:12] = 3'd0;
            // overflow carries into coarse y up to tile row 29
            if (a[9:5] == 5'd29) begin
                r[9:5] = 5'd0;
                r[11]  = ~a[11];
            end else begin
                r[9:5] = a[9:5] + 5'd1;
            end
        end
        return r;
    endfunction

    always_comb begin
        v_next = v;
        if (scr.h_scroll)
            v_next = inc_coarse_x(v_next);
        if (scr.v_scroll)
            v_next = inc_fine_y(v_next);
        // a scroll write in the same cycle holds off the copies
        if (scr.h_update && !scroll_wr) begin
            v_next[10]  = t[10];
            v_next[4:0] = t[4:0];
        end
        if (scr.v_update && !scroll_wr) begin
            v_next[14:11] = t[14:11];
            v_next[9:5]   = t[9:5];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v  <= '0;
            t  <= '0;
            fx <= '0;
        end else if (clk_en) begin
            v <= v_next;
            if (scroll_wr) begin
                t  <= scroll_t;
                fx <= fine_x_in;
            end
        end
    end

    assign scr.vaddr  = {1'b0, v};
    assign scr.fine_x = fx;

    a_copy_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(scr.h_update && scr.v_update));

endmodule

`default_nettype wire

/* hw/bg_pixel.sv */
`default_nettype none

module bg_pixel (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  clk_en,
    scan_if.snk                   scan,
    scroll_if.pix                 scr,
    input  ppu_pkg::pattern_tbl_t patt_tbl,
    input  ppu_pkg::mirror_t      mirroring,
    output logic [10:0]           vram_addr1,
    input  logic [7:0]            vram_data1,
    output logic [10:0]           vram_addr2,
    input  logic [7:0]            vram_data2,
    output logic [12:0]           chr_rom_addr1,
    input  logic [7:0]            chr_rom_data1,
    output logic [12:0]           chr_rom_addr2,
    input  logic [7:0]            chr_rom_data2,
    output logic [3:0]            bg_color_idx
);
    import ppu_pkg::*;

    logic [2:0]  tile_pixel;
    logic [2:0]  net_fx;
    logic [15:0] nt_addr;
    logic [15:0] at_addr;
    logic [1:0]  pal_idx;
    logic [12:0] pattbl_off;
    logic [2:0]  bit_idx;
    logic [1:0]  color_idx;
    logic [3:0]  raw_idx;

    // pixel position within the current tile, restarts each row
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            tile_pixel <= '0;
        else if (clk_en) begin
            if (scan.sl_col == LAST_COL)
                tile_pixel <= '0;
            else
                tile_pixel <= tile_pixel + 3'd1;
        end
    end

    assign net_fx = scr.fine_x + tile_pixel;

    // scroll requests
    assign scr.h_scroll = (net_fx == 3'd7) && (scan.vs_state == VIS_SL)
                          && (scan.hs_state == SL_PRE_CYC);
    assign scr.v_scroll = (scan.sl_col == SCROLL_V_COL) && (scan.vs_state == VIS_SL);
    // pre-render row also restores horizontal bits before row 0
    assign scr.h_update = (scan.sl_col == COPY_H_COL)
                          && (scan.vs_state == VIS_SL || scan.vs_state == PRE_SL);
    assign scr.v_update = (scan.sl_col >= COPY_V_FIRST) && (scan.sl_col <= COPY_V_LAST)
                          && (scan.vs_state == PRE_SL);

    // nametable byte holds the tile index
    assign nt_addr = NT_BASE | {4'b0, scr.vaddr[11:0]};
    vram_mirroring u_nt_mir (
        .addr      (nt_addr),
        .mirroring (mirroring),
        .vram_addr (vram_addr1)
    );

    // one attribute byte covers a 4x4 tile block
    assign at_addr = AT_BASE | {4'b0, scr.vaddr[11:10], 4'b0, scr.vaddr[9:7], scr.vaddr[4:2]};
    vram_mirroring u_at_mir (
        .addr      (at_addr),
        .mirroring (mirroring),
        .vram_addr (vram_addr2)
    );

    // quadrant from coarse y bit 1 and coarse x bit 1
    always_comb begin
        case ({scr.vaddr[6], scr.vaddr[1]})
            2'b00:   pal_idx = vram_data2[1:0];
            2'b01:   pal_idx = vram_data2[3:2];
            2'b10:   pal_idx = vram_data2[5:4];
            default: pal_idx = vram_data2[7:6];
        endcase
    end

    assign pattbl_off = (patt_tbl == RIGHT_TBL) ? 13'h1000 : 13'h0000;

    // plane 0 at +0, plane 1 at +8, row selected by fine y
    assign chr_rom_addr1 = pattbl_off | {1'b0, vram_data1, 1'b0, scr.vaddr[14:12]};
    assign chr_rom_addr2 = chr_rom_addr1 | 13'd8;

    // msb of each plane is the leftmost pixel
    assign bit_idx   = 3'd7 - net_fx;
    assign color_idx = {chr_rom_data2[bit_idx], chr_rom_data1[bit_idx]};
    assign raw_idx   = {pal_idx, color_idx};

    // colour 0 of every palette is the shared backdrop
    always_comb begin
        if (raw_idx == 4'h4 || raw_idx == 4'h8 || raw_idx == 4'hC)
            bg_color_idx = 4'h0;
        else
            bg_color_idx = raw_idx;
    end

endmodule

`default_nettype wire

/* hw/ppu_bg_top.sv */
`default_nettype none

module ppu_bg_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  clk_en,
    input  logic                  scroll_wr,
    input  logic [14:0]           scroll_t,
    input  logic [2:0]            fine_x_in,
    input  ppu_pkg::mirror_t      mirroring,
    input  ppu_pkg::pattern_tbl_t patt_tbl,
    output logic [10:0]           vram_addr1,
    output logic [10:0]           vram_addr2,
    input  logic [7:0]            vram_data1,
    input  logic [7:0]            vram_data2,
    output logic [12:0]           chr_rom_addr1,
    output logic [12:0]           chr_rom_addr2,
    input  logic [7:0]            chr_rom_data1,
    input  logic [7:0]            chr_rom_data2,
    output logic [3:0]            bg_color_idx,
    output logic [8:0]            sl_row,
    output logic [8:0]            sl_col
);

    scan_if   scan ();
    scroll_if scr ();

    ppu_timing u_timing (
        .clk    (clk),
        .rst_n  (rst_n),
        .clk_en (clk_en),
        .scan   (scan)
    );

    scroll_regs u_scroll (
        .clk       (clk),
        .rst_n     (rst_n),
        .clk_en    (clk_en),
        .scroll_wr (scroll_wr),
        .scroll_t  (scroll_t),
        .fine_x_in (fine_x_in),
        .scr       (scr)
    );

    bg_pixel u_pixel (
        .clk           (clk),
        .rst_n         (rst_n),
        .clk_en        (clk_en),
        .scan          (scan),
        .scr           (scr),
        .patt_tbl      (patt_tbl),
        .mirroring     (mirroring),
        .vram_addr1    (vram_addr1),
        .vram_data1    (vram_data1),
        .vram_addr2    (vram_addr2),
        .vram_data2    (vram_data2),
        .chr_rom_addr1 (chr_rom_addr1),
        .chr_rom_data1 (chr_rom_data1),
        .chr_rom_addr2 (chr_rom_addr2),
        .chr_rom_data2 (chr_rom_data2),
        .bg_color_idx  (bg_color_idx)
    );

    // scan position for the outside world
    assign sl_row = scan.sl_row;
    assign sl_col = scan.sl_col;

endmodule

`default_nettype wire

/* tb/ppu_bg_tb.sv */
`default_nettype none

module ppu_bg_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import ppu_pkg::*;

    localparam int MAX_CASES = 64;

    logic         clk;
    logic         rst_n;
    logic         clk_en;
    logic         scroll_wr;
    logic [14:0]  scroll_t;
    logic [2:0]   fine_x_in;
    mirror_t      mirroring;
    pattern_tbl_t patt_tbl;
    logic [10:0]  vram_addr1;
    logic [10:0]  vram_addr2;
    logic [7:0]   vram_data1;
    logic [7:0]   vram_data2;
    logic [12:0]  chr_rom_addr1;
    logic [12:0]  chr_rom_addr2;
    logic [7:0]   chr_rom_data1;
    logic [7:0]   chr_rom_data2;
    logic [3:0]   bg_color_idx;
    logic [8:0]   sl_row;
    logic [8:0]   sl_col;

    // 2 KiB vram and 8 KiB chr rom that answer in the same cycle
    logic [7:0] vram [0:2047];
    logic [7:0] chr [0:8191];

    // one entry per line of the cases file
    string        case_name [MAX_CASES];
    logic [14:0]  case_t [MAX_CASES];
    logic [2:0]   case_fx [MAX_CASES];
    mirror_t      case_mir [MAX_CASES];
    pattern_tbl_t case_tbl [MAX_CASES];
    logic [8:0]   case_row [MAX_CASES];
    logic [8:0]   case_col [MAX_CASES];
    logic [10:0]  case_nt [MAX_CASES];
    logic [10:0]  case_at [MAX_CASES];
    logic [12:0]  case_chr [MAX_CASES];

    int   case_count = 0;
    int   error_count = 0;
    int   failed_tests = 0;
    int   cycle_count = 0;
    logic loaded = 1'b0;

    ppu_bg_top uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .clk_en        (clk_en),
        .scroll_wr     (scroll_wr),
        .scroll_t      (scroll_t),
        .fine_x_in     (fine_x_in),
        .mirroring     (mirroring),
        .patt_tbl      (patt_tbl),
        .vram_addr1    (vram_addr1),
        .vram_addr2    (vram_addr2),
        .vram_data1    (vram_data1),
        .vram_data2    (vram_data2),
        .chr_rom_addr1 (chr_rom_addr1),
        .chr_rom_addr2 (chr_rom_addr2),
        .chr_rom_data1 (chr_rom_data1),
        .chr_rom_data2 (chr_rom_data2),
        .bg_color_idx  (bg_color_idx),
        .sl_row        (sl_row),
        .sl_col        (sl_col)
    );

    assign vram_data1    = vram[vram_addr1];
    assign vram_data2    = vram[vram_addr2];
    assign chr_rom_data1 = chr[chr_rom_addr1];
    assign chr_rom_data2 = chr[chr_rom_addr2];

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic fill_memories();
        logic [31:0] seed;
        seed = 32'h7e49;
        for (int i = 0; i < 2048; i++) begin
            seed = lcg_next(seed);
            vram[i] = seed[23:16];
        end
        for (int i = 0; i < 8192; i++) begin
            seed = lcg_next(seed);
            chr[i] = seed[23:16];
        end
    endtask

    task automatic load_cases();
        int    fd;
        int    r;
        int    fields;
        string line;
        string name;
        int    v_t, v_fx, v_mir, v_tbl, v_row, v_col;
        int    v_nt, v_at, v_chr;
        fd = $fopen("tb/bg_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open tb/bg_cases.txt");
            return;
        end
        while (!$feof(fd) && case_count < MAX_CASES) begin
            r = $fgets(line, fd);
            // skip comment lines
            if (r > 0 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%s %h %d %d %d %d %d %h %h %h", name, v_t, v_fx,
                                 v_mir, v_tbl, v_row, v_col, v_nt, v_at, v_chr);
                if (fields == 10) begin
                    case_name[case_count] = name;
                    case_t[case_count]    = 15'(v_t);
                    case_fx[case_count]   = 3'(v_fx);
                    case_mir[case_count]  = mirror_t'(v_mir[0]);
                    case_tbl[case_count]  = pattern_tbl_t'(v_tbl[0]);
                    case_row[case_count]  = 9'(v_row);
                    case_col[case_count]  = 9'(v_col);
                    case_nt[case_count]   = 11'(v_nt);
                    case_at[case_count]   = 11'(v_at);
                    case_chr[case_count]  = 13'(v_chr);
                    case_count++;
                end
            end
        end
        $fclose(fd);
    endtask

    // palette bits from the attribute quadrant and pixel bits from both planes
    function automatic logic [3:0] expected_color(input logic [10:0] nt_a,
                                                  input logic [10:0] at_a,
                                                  input logic [12:0] chr_a,
                                                  input logic [2:0]  net_fx);
        logic [7:0] attr;
        logic [1:0] pal;
        logic [2:0] b;
        logic [3:0] idx;
        attr = vram[at_a];
        case ({nt_a[6], nt_a[1]})
            2'b00:   pal = attr[1:0];
            2'b01:   pal = attr[3:2];
            2'b10:   pal = attr[5:4];
            default: pal = attr[7:6];
        endcase
        b = 3'd7 - net_fx;
        idx = {pal, chr[chr_a | 13'd8][b], chr[chr_a][b]};
        if (idx == 4'h4 || idx == 4'h8 || idx == 4'hC)
            idx = 4'h0;
        return idx;
    endfunction

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s %s: expected %0h, got %0h", test, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
        cycle_count++;
    endtask

    task automatic run_case(input int i);
        int          errors_before;
        logic [12:0] exp_chr;
        logic [2:0]  net_fx;
        errors_before = error_count;
        // load the scroll registers during vblank
        while (sl_row < 9'd241 || sl_row > 9'd260)
            step();
        scroll_wr = 1'b1;
        scroll_t  = case_t[i];
        fine_x_in = case_fx[i];
        mirroring = case_mir[i];
        patt_tbl  = case_tbl[i];
        step();
        scroll_wr = 1'b0;
        while (sl_row != case_row[i] || sl_col != case_col[i])
            step();
        // scan position expected from the enabled cycles since reset
        check_value(case_name[i], "sl_col", 32'(cycle_count % SL_COLS), 32'(sl_col));
        check_value(case_name[i], "sl_row",
                    32'((cycle_count / SL_COLS) % SL_ROWS), 32'(sl_row));
        // tile index comes from the nametable byte
        exp_chr = case_chr[i] | {1'b0, vram[case_nt[i]], 4'b0};
        net_fx  = case_fx[i] + case_col[i][2:0];
        check_value(case_name[i], "vram_addr1", 32'(case_nt[i]), 32'(vram_addr1));
        check_value(case_name[i], "vram_addr2", 32'(case_at[i]), 32'(vram_addr2));
        check_value(case_name[i], "chr_rom_addr1", 32'(exp_chr), 32'(chr_rom_addr1));
        check_value(case_name[i], "chr_rom_addr2", 32'(exp_chr | 13'd8), 32'(chr_rom_addr2));
        check_value(case_name[i], "bg_color_idx",
                    32'(expected_color(case_nt[i], case_at[i], exp_chr, net_fx)),
                    32'(bg_color_idx));
        if (error_count == errors_before) begin
            $display("test %s passed", case_name[i]);
        end else begin
            $display("test %s failed with %0d bad values", case_name[i],
                     error_count - errors_before);
            failed_tests++;
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        clk_en    = 1'b1;
        scroll_wr = 1'b0;
        scroll_t  = '0;
        fine_x_in = '0;
        mirroring = HORZ_MIR;
        patt_tbl  = LEFT_TBL;
        fill_memories();
        load_cases();
        loaded = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        if (case_count == 0) begin
            $display("no test cases could be read from tb/bg_cases.txt");
            $display("Finished with errors");
        end else begin
            for (int i = 0; i < case_count; i++)
                run_case(i);
            $display("tests run %0d, tests failed %0d, values wrong %0d",
                     case_count, failed_tests, error_count);
            if (error_count == 0)
                $display("Finished with no errors");
            else
                $display("Finished with errors");
        end
        $finish;
    end

    // about one frame per case and one more for reset and the first vblank
    initial begin
        longint limit;
        wait (loaded);
        limit = longint'(case_count + 1) * SL_COLS * SL_ROWS * 10;
        #(limit);
        $display("timeout: the target scan position was not reached within %0d ns", limit);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/bg_cases.txt */
# name  t_addr(hex) fine_x mirror(0 horz, 1 vert) table(0 left, 1 right) row col
# expected vram_addr1, vram_addr2, chr_rom_addr1 without tile bits (table base | fine y), all hex
nt0_horz      0000 0 0 0 0 0    000 3c0 0000
nt1_horz      0400 0 0 0 0 0    000 3c0 0000
nt1_vert      0400 0 1 0 0 0    400 7c0 0000
nt2_horz      0800 0 0 0 0 0    400 7c0 0000
nt2_vert      0800 0 1 0 0 0    000 3c0 0000
mixed_right   5db6 0 0 1 0 0    5b6 7dd 1005
quad_tr       0002 0 0 0 0 0    002 3c0 0000
quad_bl       0040 0 0 0 0 0    040 3c0 0000
quad_br       0042 0 0 0 0 0    042 3c0 0000
mid_fx0       0000 0 0 0 0 100  00c 3c3 0000
mid_fx5       0000 5 0 0 0 100  00d 3c3 0000
mid_wrap      201c 3 1 1 0 45   402 7c0 1002
row0_end      0000 0 0 0 0 255  01f 3c7 0000
row0_prefetch 0000 0 0 0 0 320  000 3c0 0001
row1_start    0000 0 0 0 1 0    002 3c0 0001
row1_carry    73a5 2 0 0 1 16   409 7c2 0000
row1_wrap     041f 0 1 1 1 8    002 3c0 1001

/* ppu_bg.f */
hw/ppu_pkg.sv
hw/ppu_ifs.sv
hw/vram_mirroring.sv
hw/ppu_timing.sv
hw/scroll_regs.sv
hw/bg_pixel.sv
hw/ppu_bg_top.sv
tb/ppu_bg_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the background pixel testbench with Verilator
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module ppu_bg_tb -f ppu_bg.f -o ppu_bg_sim \
    && ./obj_dir/ppu_bg_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -q "Finished with errors" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "no result found in sim.log"; exit 1; }
echo "simulation passed"
